/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module memSubsystemTb -Mdir obj_dir

output=$(./obj_dir/VmemSubsystemTb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1

/* source/addrDecoder.sv */
`timescale 1ns/1ns

module addrDecoder (
   input  logic               clk,
   input  logic               rst,
   input  busCfgPkg::addrT    addr,
   input  logic               we,
   input  logic               clkEn,
   output logic               progWe,
   output logic               vecWrite,
   output memMapPkg::regionT  rdRegion,
   output busCfgPkg::addrT    rdAddr,
   output logic               vgGo,
   output logic               vgRst
);

   import busCfgPkg::*;
   import memMapPkg::*;

   regionT region;

   // --------------------------------------------------
   // address classification
   // --------------------------------------------------

   // program RAM starts at zero, so only the upper bound needs a compare
   always_comb begin
      if (addr <= progLimit) begin
         region = REG_PROG;
      end else if (addr >= vecBase && addr <= vecLimit) begin
         region = REG_VECTOR;
      end else if (addr == statusAddr || addr == dsw0Addr || addr == dsw1Addr) begin
         region = REG_SWITCH;
      end else begin
         region = REG_NONE;
      end
   end

   assign progWe   = we && clkEn && (region == REG_PROG);
   assign vecWrite = we && (region == REG_VECTOR); // level, the queue finds the edge

   // strobes last only for the clkEn cycle of the write
   assign vgGo  = we && clkEn && (addr == vgGoAddr);
   assign vgRst = we && clkEn && (addr == vgRstAddr);

   // --------------------------------------------------
   // read return select
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         rdRegion <= REG_NONE; // a read straight after reset returns zero
      end else if (clkEn) begin
         rdRegion <= region;
      end
   end

   always_ff @(posedge clk) begin
      if (clkEn) begin
         rdAddr <= addr; // picks the switch bank on the next cycle
      end
   end

   // the generator cannot be started and reset by the same access
   vgStrobeExclusive: assert property (@(posedge clk) disable iff (rst)
      !(vgGo && vgRst))
      else $error("vgGo and vgRst high together");

endmodule

/* source/bankStore.sv */
`timescale 1ns/1ns

module bankStore #(
   parameter int progWords = 2048,
   parameter int vecWords  = 8192
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               clkEn,
   input  busCfgPkg::addrT    addr,
   input  busCfgPkg::dataT    dataFromCore,
   input  logic               progWe,
   input  memMapPkg::regionT  rdRegion,
   input  busCfgPkg::addrT    rdAddr,
   input  busCfgPkg::addrT    qAddr,
   input  busCfgPkg::dataT    qData,
   input  logic               dataValid,
   input  busCfgPkg::dataT    dsw0,
   input  busCfgPkg::dataT    dsw1,
   input  logic               selfTest,
   input  logic               coin,
   output busCfgPkg::dataT    dataToCore
);

   import busCfgPkg::*;
   import memMapPkg::*;

   localparam int progAW = $clog2(progWords);
   localparam int vecAW  = $clog2(vecWords);

   // both RAMs power up cleared, as the block RAM init does
   dataT progRam [progWords] = '{default: '0};
   dataT vecRam  [vecWords]  = '{default: '0};

   logic [progAW-1:0] progIdx;
   logic [vecAW-1:0]  vecRdIdx;
   logic [vecAW-1:0]  vecWrIdx;

   dataT progRd;
   dataT vecRd;
   dataT statusByte;

   assign progIdx  = progAW'(addr - progBase);
   assign vecRdIdx = vecAW'(addr - vecBase);
   assign vecWrIdx = vecAW'(qAddr - vecBase); // queue side, independent of the CPU address

   // --------------------------------------------------
   // program RAM
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (progWe) progRam[progIdx] <= dataFromCore;
      if (clkEn) progRd <= progRam[progIdx];
   end

   // --------------------------------------------------
   // vector RAM
   // --------------------------------------------------

   // only the drained queue writes here, the CPU never reaches this RAM directly
   always_ff @(posedge clk) begin
      if (dataValid) vecRam[vecWrIdx] <= qData;
      if (clkEn) vecRd <= vecRam[vecRdIdx];
   end

   // --------------------------------------------------
   // read return
   // --------------------------------------------------

   // unused status bits read as ones
   assign statusByte = {3'b111, selfTest, 3'b111, coin};

   always_comb begin
      case (rdRegion)
         REG_PROG:   dataToCore = progRd;
         REG_VECTOR: dataToCore = vecRd;
         REG_SWITCH: begin
            if (rdAddr == statusAddr) dataToCore = statusByte;
            else if (rdAddr == dsw0Addr) dataToCore = dsw0;
            else if (rdAddr == dsw1Addr) dataToCore = dsw1;
            else dataToCore = '0;
         end
         default:    dataToCore = '0;
      endcase
   end

   // entries only get into the queue through a vector region decode
   vecWriteInRange: assert property (@(posedge clk) disable iff (rst)
      dataValid |-> (qAddr >= vecBase && qAddr <= vecLimit))
      else $error("vector RAM write outside the vector window");

endmodule

/* source/busCfgPkg.sv */
package busCfgPkg;

   // --------------------------------------------------
   // CPU bus widths
   // --------------------------------------------------

   // the 6502-style core drives a 16 bit address and an 8 bit data bus
   parameter int addrW = 16;
   parameter int dataW = 8;

   // --------------------------------------------------
   // bus types
   // --------------------------------------------------

   typedef logic [addrW-1:0] addrT; // full CPU address
   typedef logic [dataW-1:0] dataT; // one data byte

endpackage

/* source/memMapPkg.sv */
package memMapPkg;

   // --------------------------------------------------
   // regions
   // --------------------------------------------------

   // region an address falls into, registered by the decoder for the read return
   typedef enum logic [1:0] {
      REG_PROG,   // program RAM
      REG_VECTOR, // vector RAM, written through the store queue
      REG_SWITCH, // status byte and the two switch banks
      REG_NONE    // unmapped, reads back zero
   } regionT;

   // --------------------------------------------------
   // RAM windows
   // --------------------------------------------------

   parameter busCfgPkg::addrT progBase  = 16'h0000;
   parameter busCfgPkg::addrT progLimit = 16'h07FF;

   parameter busCfgPkg::addrT vecBase   = 16'h2000;
   parameter busCfgPkg::addrT vecLimit  = 16'h3FFF;

   // --------------------------------------------------
   // single-address registers
   // --------------------------------------------------

   // inputs read by the CPU
   parameter busCfgPkg::addrT statusAddr = 16'h0800;
   parameter busCfgPkg::addrT dsw0Addr   = 16'h0A00;
   parameter busCfgPkg::addrT dsw1Addr   = 16'h0C00;

   // vector generator strobes, a write of any value fires them
   parameter busCfgPkg::addrT vgGoAddr   = 16'h1200;
   parameter busCfgPkg::addrT vgRstAddr  = 16'h1600;

endpackage

/* source/memStoreQueue.sv */
`timescale 1ns/1ns

module memStoreQueue #(
   parameter int queueDepth = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  busCfgPkg::dataT  dataIn,
   input  busCfgPkg::addrT  addrIn,
   input  logic             writeEn,
   input  logic             canWrite,
   output busCfgPkg::dataT  dataOut,
   output busCfgPkg::addrT  addrOut,
   output logic             dataValid,
   output logic             full,
   output logic             empty
);

   import busCfgPkg::*;

   localparam int idxW = $clog2(queueDepth);

   dataT dataMem [queueDepth];
   addrT addrMem [queueDepth];

   logic [idxW-1:0] wrIdx;
   logic [idxW-1:0] rdIdx;
   logic [idxW:0]   fillCount;

   logic writeEnLast;
   logic writeEdge;
   logic push;
   logic pop;

   // --------------------------------------------------
   // push and pop conditions
   // --------------------------------------------------

   // the CPU holds we for more than one cycle, so only the rising edge enqueues
   assign writeEdge = writeEn && !writeEnLast;
   assign push      = writeEdge && !full; // a write into a full queue is lost
   assign pop       = canWrite && !empty;

   assign full  = (fillCount == (idxW+1)'(queueDepth));
   assign empty = (fillCount == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         writeEnLast <= 1'b0;
         wrIdx       <= '0;
         rdIdx       <= '0;
         fillCount   <= '0;
      end else begin
         writeEnLast <= writeEn;
         if (push) wrIdx <= wrIdx + 1'b1; // indices wrap since depth is a power of two
         if (pop) rdIdx <= rdIdx + 1'b1;
         case ({push, pop})
            2'b10:   fillCount <= fillCount + 1'b1;
            2'b01:   fillCount <= fillCount - 1'b1;
            default: fillCount <= fillCount;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         dataMem[wrIdx] <= dataIn;
         addrMem[wrIdx] <= addrIn;
      end
   end

   // --------------------------------------------------
   // head entry
   // --------------------------------------------------

   assign dataOut   = dataMem[rdIdx];
   assign addrOut   = addrMem[rdIdx];
   assign dataValid = !empty && canWrite; // the bank store writes whenever this is high

   occupancyBound: assert property (@(posedge clk) disable iff (rst)
      fillCount <= (idxW+1)'(queueDepth))
      else $error("queue fill count above depth");

   fullEmptyExclusive: assert property (@(posedge clk) disable iff (rst)
      !(full && empty))
      else $error("queue reports full and empty together");

endmodule

/* source/memSubsystem.sv */
`timescale 1ns/1ns

module memSubsystem #(
   parameter int queueDepth = 16,
   parameter int progWords  = 2048,
   parameter int vecWords   = 8192
) (
   input  logic             clk,
   input  logic             rst,
   input  busCfgPkg::addrT  addr,
   input  busCfgPkg::dataT  dataFromCore,
   input  logic             we,
   input  logic             clkEn,
   input  logic             canWrite,
   input  busCfgPkg::dataT  dsw0,
   input  busCfgPkg::dataT  dsw1,
   input  logic             selfTest,
   input  logic             coin,
   output busCfgPkg::dataT  dataToCore,
   output logic             vgGo,
   output logic             vgRst,
   output logic             full,
   output logic             empty
);

   import busCfgPkg::*;
   import memMapPkg::*;

   logic   progWe;
   logic   vecWrite;
   regionT rdRegion;
   addrT   rdAddr;

   addrT   qAddr;
   dataT   qData;
   logic   dataValid;

   // --------------------------------------------------
   // decoder and store queue side by side
   // --------------------------------------------------

   addrDecoder decoder (
      .clk      (clk),
      .rst      (rst),
      .addr     (addr),
      .we       (we),
      .clkEn    (clkEn),
      .progWe   (progWe),
      .vecWrite (vecWrite),
      .rdRegion (rdRegion),
      .rdAddr   (rdAddr),
      .vgGo     (vgGo),
      .vgRst    (vgRst)
   );

   memStoreQueue #(.queueDepth(queueDepth)) storeQueue (
      .clk       (clk),
      .rst       (rst),
      .dataIn    (dataFromCore),
      .addrIn    (addr),
      .writeEn   (vecWrite),
      .canWrite  (canWrite),
      .dataOut   (qData),
      .addrOut   (qAddr),
      .dataValid (dataValid),
      .full      (full),
      .empty     (empty)
   );

   // --------------------------------------------------
   // RAM banks
   // --------------------------------------------------

   bankStore #(.progWords(progWords), .vecWords(vecWords)) banks (
      .clk          (clk),
      .rst          (rst),
      .clkEn        (clkEn),
      .addr         (addr),
      .dataFromCore (dataFromCore),
      .progWe       (progWe),
      .rdRegion     (rdRegion),
      .rdAddr       (rdAddr),
      .qAddr        (qAddr),
      .qData        (qData),
      .dataValid    (dataValid),
      .dsw0         (dsw0),
      .dsw1         (dsw1),
      .selfTest     (selfTest),
      .coin         (coin),
      .dataToCore   (dataToCore)
   );

endmodule

/* tb.f */
source/busCfgPkg.sv
source/memMapPkg.sv
source/addrDecoder.sv
source/memStoreQueue.sv
source/bankStore.sv
source/memSubsystem.sv
tests/memSubsystemTb.sv

/* tests/memSubsystemTb.sv */
`timescale 1ns/1ns

module memSubsystemTb;

   import busCfgPkg::*;

   localparam int queueDepth = 16;

   logic clk = 1'b0;
   logic rst;
   addrT addr;
   dataT dataFromCore;
   logic we;
   logic clkEn;
   logic canWrite;
   dataT dsw0;
   dataT dsw1;
   logic selfTest;
   logic coin;
   dataT dataToCore;
   logic vgGo;
   logic vgRst;
   logic full;
   logic empty;

   // shadow memories and the model of the store queue
   dataT progShadow [2048] = '{default: '0};
   dataT vecShadow  [8192] = '{default: '0};
   addrT modelAddr  [queueDepth];
   dataT modelData  [queueDepth];
   int modelCount = 0;

   int unsigned lcgState = 35427;
   logic checkPending = 1'b0;
   dataT expData;
   addrT expAddr;

   memSubsystem #(.queueDepth(queueDepth)) uut (
      .clk(clk), .rst(rst), .addr(addr), .dataFromCore(dataFromCore), .we(we),
      .clkEn(clkEn), .canWrite(canWrite), .dsw0(dsw0), .dsw1(dsw1),
      .selfTest(selfTest), .coin(coin), .dataToCore(dataToCore),
      .vgGo(vgGo), .vgRst(vgRst), .full(full), .empty(empty)
   );

   always #20 clk = ~clk;

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   function automatic int unsigned lcgNext();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState >> 8; // low bits of this LCG cycle too quickly
   endfunction

   // expected read data, built from the memory map and the status byte layout
   function automatic dataT refRead(input addrT a);
      if (a <= 16'h07FF) return progShadow[a[10:0]];
      if (a >= 16'h2000 && a <= 16'h3FFF) return vecShadow[a[12:0]];
      if (a == 16'h0800) return 8'hEE | {3'b000, selfTest, 3'b000, coin};
      if (a == 16'h0A00) return dsw0;
      if (a == 16'h0C00) return dsw1;
      return 8'h00;
   endfunction

   task automatic stopRun();
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic valueError(input string msg);
      $display("ERR %0t: %s", $time, msg);
      stopRun();
   endtask

   // one CPU access, we is held a cycle past the clkEn cycle
   task automatic access(input addrT a, input dataT d, input logic w);
      if (w && a <= 16'h07FF) progShadow[a[10:0]] = d;
      if (w && a >= 16'h2000 && a <= 16'h3FFF && modelCount < queueDepth) begin
         modelAddr[modelCount] = a;
         modelData[modelCount] = d;
         modelCount++; // a write into a full queue is lost
      end
      @(posedge clk);
      addr <= a;
      dataFromCore <= d;
      we <= w;
      clkEn <= 1'b1;
      @(negedge clk);
      assert (vgGo === (w && a == 16'h1200) && vgRst === (w && a == 16'h1600))
         else valueError($sformatf("strobes go=%b rst=%b at %h", vgGo, vgRst, a));
      @(posedge clk);
      clkEn <= 1'b0;
      if (!w) begin
         expData = refRead(a);
         expAddr = a;
         checkPending = 1'b1;
      end
      @(negedge clk);
      assert (!vgGo && !vgRst) else valueError("strobe high after the clkEn cycle");
      @(posedge clk);
      we <= 1'b0;
   endtask

   task automatic waitEmpty();
      int cycles;
      cycles = 0;
      while (!empty && cycles < 2000) begin
         @(negedge clk);
         cycles++;
      end
      if (!empty) begin
         $display("timeout: the store queue never drained");
         stopRun();
      end
      for (int i = 0; i < modelCount; i++) vecShadow[modelAddr[i][12:0]] = modelData[i];
      modelCount = 0;
   endtask

   // compare process, the read data is stable by the falling edge
   always @(negedge clk) begin
      if (checkPending) begin
         assert (dataToCore === expData)
            else valueError($sformatf("read %h got %h expected %h", expAddr, dataToCore, expData));
         checkPending = 1'b0;
      end
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------

   initial begin
      addrT progAddrs [40];
      addrT vecAddrs [20];
      rst = 1'b1;
      addr = '0;
      dataFromCore = '0;
      we = 1'b0;
      clkEn = 1'b0;
      canWrite = 1'b0;
      dsw0 = '0;
      dsw1 = '0;
      selfTest = 1'b0;
      coin = 1'b0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      assert (empty && !full && !vgGo && !vgRst && dataToCore === 8'h00)
         else valueError($sformatf("reset state empty=%b full=%b data=%h", empty, full, dataToCore));
      access(16'h0123, 8'h00, 1'b0);
      access(16'h2345, 8'h00, 1'b0);

      for (int i = 0; i < 40; i++) begin
         progAddrs[i] = addrT'(lcgNext() % 2048);
         access(progAddrs[i], dataT'(lcgNext()), 1'b1);
      end
      for (int i = 0; i < 40; i++) access(progAddrs[i], 8'h00, 1'b0);

      // back-pressure, the last four writes meet a full queue
      for (int i = 0; i < queueDepth + 4; i++) begin
         vecAddrs[i] = addrT'(16'h2100 + i * 3);
         access(vecAddrs[i], dataT'(lcgNext() % 255 + 1), 1'b1);
         @(negedge clk);
         assert (!empty && full === (i >= queueDepth - 1))
            else valueError($sformatf("write %0d empty=%b full=%b", i, empty, full));
      end
      @(posedge clk);
      canWrite <= 1'b1;
      waitEmpty();
      for (int i = 0; i < queueDepth + 4; i++) access(vecAddrs[i], 8'h00, 1'b0);

      for (int i = 0; i < queueDepth; i++) begin
         @(posedge clk);
         canWrite <= 1'(lcgNext() >> 5);
         vecAddrs[i] = addrT'(16'h2000 + lcgNext() % 8192);
         access(vecAddrs[i], dataT'(lcgNext()), 1'b1);
      end
      @(posedge clk);
      canWrite <= 1'b1;
      waitEmpty();
      for (int i = 0; i < queueDepth; i++) access(vecAddrs[i], 8'h00, 1'b0);

      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         dsw0 <= dataT'(lcgNext());
         dsw1 <= dataT'(lcgNext());
         selfTest <= 1'(lcgNext() >> 4);
         coin <= 1'(lcgNext() >> 4);
         access(16'h0A00, 8'h00, 1'b0);
         access(16'h0C00, 8'h00, 1'b0);
         access(16'h0800, 8'h00, 1'b0);
         access(16'h1000, 8'h00, 1'b0);
      end

      access(16'h1200, 8'h5A, 1'b1); // strobe checks live in the access task
      access(16'h1600, 8'hA5, 1'b1);
      access(16'h1200, 8'h00, 1'b0);
      access(16'h1600, 8'h00, 1'b0);

      @(negedge clk);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
